//--- verilog.f
src/core_pkg.sv
src/stage_fetch.sv
src/stage_decode.sv
src/stage_execute.sv
src/stage_memory.sv
src/pipeline_control.sv
src/bus_arbiter.sv
src/core.sv
sim/wb_memory.sv
sim/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
rm -f sim.log
verilator --binary --timing --assert --top-module tb_core -f verilog.f -o tb_core_sim \
    && ./obj_dir/tb_core_sim | tee sim.log
grep -qx "No errors" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- sim/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core import core_pkg::*; ();

    localparam int reset_cycles = 16;
    localparam int max_wait     = 3;
    localparam int data_adr     = 'h0800;
    localparam int result_adr   = 'h0a00;
    localparam int poison_adr   = 'h0c00;

    logic    clk = 1'b0;
    logic    reset = 1'b1;
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;
    logic    marker_seen;
    int      program_length = 0;
    int      store_count = 0;
    int      errors = 0;

    core DUT (
        .clk(clk), .reset(reset), .bus_req(bus_req), .bus_rsp(bus_rsp)
    );

    wb_memory MEM (
        .clk(clk), .reset(reset), .bus_req(bus_req), .bus_rsp(bus_rsp),
        .marker_seen(marker_seen)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] encode_r(input logic [5:0] funct, input logic [4:0] rd,
                                             input logic [4:0] rs, input logic [4:0] rt);
        return {op_rtype, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rt,
                                             input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic place(input logic [31:0] word);
        MEM.mem[10'(program_length)] = word;
        program_length++;
    endtask

    // sw to the next result word, plus its expected value
    task automatic store_result(input logic [4:0] rt, input logic [31:0] value);
        logic [9:0] index;
        index = 10'((result_adr >> 2) + store_count);
        place(encode_i(op_sw, rt, 5'd0, 16'(result_adr + 4 * store_count)));
        MEM.enabled[index]  = 1'b1;
        MEM.expected[index] = value;
        MEM.order[index]    = store_count;
        store_count++;
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [15:0] imm;
        logic [31:0] sum;
        a   = $urandom();
        b   = $urandom();
        c   = $urandom();
        imm = 16'($urandom());
        sum = a + b;
        MEM.mem[10'(data_adr >> 2)]       = a;
        MEM.mem[10'((data_adr >> 2) + 1)] = b;
        MEM.mem[10'((data_adr >> 2) + 2)] = c;
        place(encode_i(op_lw, 5'd1, 5'd0, 16'(data_adr)));
        place(encode_i(op_lw, 5'd2, 5'd0, 16'(data_adr + 4)));
        // the first add also waits on the second load
        place(encode_r(fn_add, 5'd3, 5'd1, 5'd2));
        store_result(5'd3, sum);
        place(encode_r(fn_sub, 5'd4, 5'd1, 5'd2));
        store_result(5'd4, a - b);
        place(encode_r(fn_and, 5'd5, 5'd1, 5'd2));
        store_result(5'd5, a & b);
        place(encode_r(fn_or, 5'd6, 5'd1, 5'd2));
        store_result(5'd6, a | b);
        place(encode_r(fn_slt, 5'd7, 5'd1, 5'd2));
        store_result(5'd7, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        place(encode_i(op_addi, 5'd8, 5'd1, imm));
        store_result(5'd8, a + {{16{imm[15]}}, imm});
        // chain at distance 1 and 2
        place(encode_r(fn_add, 5'd9, 5'd1, 5'd2));
        place(encode_r(fn_sub, 5'd10, 5'd9, 5'd1));
        place(encode_r(fn_add, 5'd11, 5'd9, 5'd10));
        store_result(5'd11, sum + b);
        place(encode_i(op_lw, 5'd12, 5'd0, 16'(data_adr + 8)));
        place(encode_r(fn_add, 5'd13, 5'd12, 5'd1));
        store_result(5'd13, c + a);
        // taken, skips two poison stores
        place(encode_i(op_beq, 5'd1, 5'd1, 16'd2));
        place(encode_i(op_sw, 5'd1, 5'd0, 16'(poison_adr)));
        place(encode_i(op_sw, 5'd2, 5'd0, 16'(poison_adr + 4)));
        place(encode_i(op_addi, 5'd14, 5'd0, 16'd1));
        place(encode_i(op_beq, 5'd0, 5'd14, 16'd2));
        store_result(5'd14, 32'd1);
        // final marker word
        place(encode_i(op_addi, 5'd15, 5'd0, 16'h600d));
        store_result(5'd15, 32'h0000_600d);
        place(encode_i(op_beq, 5'd0, 5'd0, 16'hffff));
        MEM.store_total = store_count;
    endtask

    assert property (@(posedge clk) disable iff (reset) bus_req.stb |-> bus_req.cyc)
    else begin
        errors++;
        $display("bus protocol broken at %0t ns: stb is high while cyc is low", $time);
    end

    assert property (@(posedge clk) disable iff (reset)
        bus_req.stb && !bus_rsp.ack |=> bus_req.stb && $stable(bus_req.adr) &&
                                        $stable(bus_req.we) && $stable(bus_req.dat_w))
    else begin
        errors++;
        $display("bus protocol broken at %0t ns: request changed before its ack", $time);
    end

    assert property (@(posedge clk) disable iff (reset) bus_rsp.ack |-> bus_req.stb)
    else begin
        errors++;
        $display("bus protocol broken at %0t ns: ack arrived without stb", $time);
    end

    assert property (@(posedge clk) $fell(reset) |-> !bus_req.cyc)
    else begin
        errors++;
        $display("bus protocol broken at %0t ns: cyc high in the first cycle", $time);
    end

    initial begin
        void'($urandom(32'h6b38));
        repeat (2) @(posedge clk);
        build_program();
        repeat (reset_cycles - 2) @(posedge clk);
        #1;
        reset = 1'b0;
        wait (marker_seen);
        // let the core spin in its final loop for a while
        repeat (20) @(posedge clk);
        assert (MEM.next_store == store_count)
        else begin
            errors++;
            $display("** Error (%0t): %0d result stores seen, expected %0d", $time,
                     MEM.next_store, store_count);
        end
        $display("failed checks: bus %0d, memory %0d", errors, MEM.error_count);
        if (errors + MEM.error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        @(negedge reset);
        repeat (program_length * 40 * max_wait) @(posedge clk);
        $display("timeout: the program did not finish within %0d cycles",
                 program_length * 40 * max_wait);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/wb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module wb_memory import core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t bus_req,
    output wb_rsp_t bus_rsp,
    output logic    marker_seen
);

    localparam int max_wait = 3;

    logic [xlen-1:0] mem      [1024];
    // result area, filled in by the testbench before reset ends
    logic [xlen-1:0] expected [1024];
    logic            enabled  [1024];
    int              order    [1024];
    int              store_total = 0;
    int              next_store;
    int              error_count = 0;

    logic            ack = 1'b0;
    logic [xlen-1:0] rdata = '0;
    int unsigned     wait_cycles;
    int unsigned     count;
    logic [9:0]      index;
    logic            store_ok;
    logic [xlen-1:0] want_data;
    int              want_order;

    assign index         = bus_req.adr[11:2];
    assign bus_rsp.ack   = ack;
    assign bus_rsp.dat_r = rdata;
    assign store_ok      = (bus_req.adr[31:12] == '0) && enabled[index];
    assign want_data     = expected[index];
    assign want_order    = order[index];

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[10'(i)]      = (32'(i) * 32'h9e37_79b9) ^ 32'h5ca1_ab1e;
            expected[10'(i)] = '0;
            enabled[10'(i)]  = 1'b0;
            order[10'(i)]    = -1;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            ack         <= 1'b0;
            count       <= 0;
            wait_cycles <= 0;
            next_store  <= 0;
            marker_seen <= 1'b0;
        end else begin
            ack <= 1'b0;
            if (ack && bus_req.we && store_ok) begin
                next_store <= next_store + 1;
                if (want_order == store_total - 1) begin
                    marker_seen <= 1'b1;
                end
            end
            // a new wait count starts with every stb after an ack
            if (bus_req.stb && !ack) begin
                if (count == wait_cycles) begin
                    ack         <= 1'b1;
                    count       <= 0;
                    wait_cycles <= $urandom_range(max_wait, 0);
                    if (bus_req.we) begin
                        mem[index] = bus_req.dat_w;
                    end else begin
                        rdata <= mem[index];
                    end
                end else begin
                    count <= count + 1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        ack && bus_req.we |-> store_ok)
    else begin
        error_count++;
        $display("store to address %h outside the result area at %0t ns",
                 $sampled(bus_req.adr), $time);
    end

    assert property (@(posedge clk) disable iff (reset)
        ack && bus_req.we && store_ok |-> bus_req.dat_w == want_data)
    else begin
        error_count++;
        $display("** Error (%0t): result at %h is %h, expected %h", $time,
                 $sampled(bus_req.adr), $sampled(bus_req.dat_w), $sampled(want_data));
    end

    // result words come in program order, each one once
    assert property (@(posedge clk) disable iff (reset)
        ack && bus_req.we && store_ok |-> want_order == next_store)
    else begin
        error_count++;
        $display("** Error (%0t): store to %h is number %0d, expected number %0d", $time,
                 $sampled(bus_req.adr), $sampled(next_store), $sampled(want_order));
    end

endmodule

`default_nettype wire

//--- src/core.sv
`timescale 1ns/1ps
`default_nettype none

module core import core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp
);

    wb_req_t         ins_req;
    wb_rsp_t         ins_rsp;
    wb_req_t         data_req;
    wb_rsp_t         data_rsp;
    instr_t          instruction;
    logic [xlen-1:0] pc_add4;
    logic            fetch_valid;
    logic            fetch_busy;
    logic            data_busy;
    id_ex_t          decoded;
    ex_mem_t         executed;
    wb_t             wb;
    logic [4:0]      rs;
    logic [4:0]      rt;
    fwd_sel_t        fwd_a;
    fwd_sel_t        fwd_b;
    logic            stall_front;
    logic            bubble;
    logic            freeze;
    logic            flush;
    logic            branch_taken;
    logic [xlen-1:0] branch_target;
    logic [xlen-1:0] mem_result;

    stage_fetch unit_fetch (
        .clk(clk), .reset(reset),
        .stall(stall_front), .redirect(flush), .target(branch_target), .flush(flush),
        .bus_req(ins_req), .bus_rsp(ins_rsp),
        .instruction(instruction), .pc_add4(pc_add4), .valid(fetch_valid),
        .busy(fetch_busy)
    );

    stage_decode unit_decode (
        .clk(clk), .reset(reset),
        .stall(stall_front), .bubble(bubble), .flush(flush), .freeze(freeze),
        .instruction(instruction), .pc_add4(pc_add4), .valid(fetch_valid),
        .wb(wb), .decoded(decoded), .rs(rs), .rt(rt)
    );

    stage_execute unit_execute (
        .clk(clk), .reset(reset), .freeze(freeze),
        .decoded(decoded), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_result(mem_result), .wb_result(wb.data),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .executed(executed)
    );

    stage_memory unit_memory (
        .clk(clk), .reset(reset), .freeze(freeze),
        .executed(executed), .bus_req(data_req), .bus_rsp(data_rsp),
        .busy(data_busy), .mem_result(mem_result), .wb(wb)
    );

    pipeline_control unit_control (
        .id_ex(decoded), .ex_mem(executed), .wb(wb), .rs(rs), .rt(rt),
        .fetch_busy(fetch_busy), .data_busy(data_busy), .branch_taken(branch_taken),
        .fwd_a(fwd_a), .fwd_b(fwd_b),
        .stall_front(stall_front), .bubble(bubble), .freeze(freeze), .flush(flush)
    );

    bus_arbiter unit_arbiter (
        .clk(clk), .reset(reset),
        .ins_req(ins_req), .ins_rsp(ins_rsp),
        .data_req(data_req), .data_rsp(data_rsp),
        .bus_req(bus_req), .bus_rsp(bus_rsp)
    );

endmodule

`default_nettype wire

//--- src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import core_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t ins_req,
    output wb_rsp_t ins_rsp,
    input  wb_req_t data_req,
    output wb_rsp_t data_rsp,
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp
);

    logic locked;
    logic owner_data;
    logic grant_data;

    // data side first, unless a transfer is already under way
    assign grant_data = locked ? owner_data : data_req.cyc;

    assign bus_req = grant_data ? data_req : ins_req;

    always_comb begin
        ins_rsp.dat_r  = bus_rsp.dat_r;
        data_rsp.dat_r = bus_rsp.dat_r;
        ins_rsp.ack    = bus_rsp.ack && !grant_data;
        data_rsp.ack   = bus_rsp.ack && grant_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            locked     <= 1'b0;
            owner_data <= 1'b0;
        end else if (bus_rsp.ack) begin
            locked <= 1'b0;
        end else if (bus_req.stb && !locked) begin
            locked     <= 1'b1;
            owner_data <= grant_data;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (ins_rsp.ack |-> ins_req.stb) and (data_rsp.ack |-> data_req.stb));

    assert property (@(posedge clk) disable iff (reset)
        bus_req.stb |-> bus_req.cyc);

endmodule

`default_nettype wire

//--- src/pipeline_control.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_control import core_pkg::*; (
    input  id_ex_t     id_ex,
    input  ex_mem_t    ex_mem,
    input  wb_t        wb,
    input  logic [4:0] rs,
    input  logic [4:0] rt,
    input  logic       fetch_busy,
    input  logic       data_busy,
    input  logic       branch_taken,
    output fwd_sel_t   fwd_a,
    output fwd_sel_t   fwd_b,
    output logic       stall_front,
    output logic       bubble,
    output logic       freeze,
    output logic       flush
);

    logic mem_writes;
    logic wb_writes;
    logic load_use;

    assign mem_writes = ex_mem.valid && ex_mem.ctrl.write_reg && (ex_mem.dest != 5'd0);
    assign wb_writes  = wb.valid && wb.write_reg && (wb.dest != 5'd0);

    // the younger result wins
    assign fwd_a = (mem_writes && ex_mem.dest == id_ex.rs) ? fwd_mem :
                   (wb_writes && wb.dest == id_ex.rs)      ? fwd_wb  : fwd_reg;
    assign fwd_b = (mem_writes && ex_mem.dest == id_ex.rt) ? fwd_mem :
                   (wb_writes && wb.dest == id_ex.rt)      ? fwd_wb  : fwd_reg;

    // load data is only ready from the write-back slot
    assign load_use = id_ex.valid && id_ex.ctrl.mem_read && (id_ex.dest != 5'd0) &&
                      (id_ex.dest == rs || id_ex.dest == rt);

    assign freeze      = fetch_busy || data_busy;
    assign stall_front = freeze || load_use;
    assign bubble      = load_use && !freeze;
    assign flush       = branch_taken && !freeze;

endmodule

`default_nettype wire

//--- src/stage_memory.sv
`timescale 1ns/1ps
`default_nettype none

module stage_memory import core_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            freeze,
    input  ex_mem_t         executed,
    output wb_req_t         bus_req,
    input  wb_rsp_t         bus_rsp,
    output logic            busy,
    output logic [xlen-1:0] mem_result,
    output wb_t             wb
);

    logic            mem_access;
    logic            done;
    logic [xlen-1:0] load_word;

    assign mem_access = executed.valid && (executed.ctrl.mem_read || executed.ctrl.mem_write);

    // one transfer per entry, even if the pipe stays frozen after ack
    assign bus_req.cyc   = mem_access && !done;
    assign bus_req.stb   = mem_access && !done;
    assign bus_req.we    = executed.ctrl.mem_write;
    assign bus_req.adr   = executed.alu_result;
    assign bus_req.dat_w = executed.store_data;
    assign busy          = bus_req.stb && !bus_rsp.ack;
    assign mem_result    = executed.alu_result;

    always_ff @(posedge clk) begin
        if (bus_rsp.ack) begin
            load_word <= bus_rsp.dat_r;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done     <= 1'b0;
            wb.valid <= 1'b0;
        end else if (freeze) begin
            if (bus_rsp.ack) begin
                done <= 1'b1;
            end
        end else begin
            done         <= 1'b0;
            wb.valid     <= executed.valid;
            wb.write_reg <= executed.ctrl.write_reg;
            wb.dest      <= executed.dest;
            if (!executed.ctrl.mem_read) begin
                wb.data <= executed.alu_result;
            end else if (done) begin
                wb.data <= load_word;
            end else begin
                wb.data <= bus_rsp.dat_r;
            end
        end
    end

    // a write cycle only ever comes from a store
    assert property (@(posedge clk) disable iff (reset)
        bus_req.stb && bus_req.we |-> !executed.ctrl.mem_read && !executed.ctrl.write_reg);

endmodule

`default_nettype wire

//--- src/stage_execute.sv
`timescale 1ns/1ps
`default_nettype none

module stage_execute import core_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            freeze,
    input  id_ex_t          decoded,
    input  fwd_sel_t        fwd_a,
    input  fwd_sel_t        fwd_b,
    input  logic [xlen-1:0] mem_result,
    input  logic [xlen-1:0] wb_result,
    output logic            branch_taken,
    output logic [xlen-1:0] branch_target,
    output ex_mem_t         executed
);

    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_rt;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] alu_result;

    always_comb begin
        case (fwd_a)
            fwd_mem: operand_a = mem_result;
            fwd_wb:  operand_a = wb_result;
            default: operand_a = decoded.rs_data;
        endcase
        case (fwd_b)
            fwd_mem: operand_rt = mem_result;
            fwd_wb:  operand_rt = wb_result;
            default: operand_rt = decoded.rt_data;
        endcase
    end

    assign operand_b = decoded.ctrl.use_imm ? decoded.imm : operand_rt;

    always_comb begin
        case (decoded.ctrl.alu_op)
            alu_sub: alu_result = operand_a - operand_b;
            alu_and: alu_result = operand_a & operand_b;
            alu_or:  alu_result = operand_a | operand_b;
            alu_slt: alu_result = xlen'($signed(operand_a) < $signed(operand_b));
            default: alu_result = operand_a + operand_b;
        endcase
    end

    // beq compares the two register operands
    assign branch_taken  = decoded.valid && decoded.ctrl.branch && (operand_a == operand_rt);
    assign branch_target = decoded.pc_add4 + {decoded.imm[xlen-3:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            executed.valid <= 1'b0;
        end else if (!freeze) begin
            executed.valid      <= decoded.valid;
            executed.ctrl       <= decoded.ctrl;
            executed.dest       <= decoded.dest;
            executed.alu_result <= alu_result;
            executed.store_data <= operand_rt;
        end
    end

endmodule

`default_nettype wire

//--- src/stage_decode.sv
`timescale 1ns/1ps
`default_nettype none

module stage_decode import core_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            bubble,
    input  logic            flush,
    input  logic            freeze,
    input  instr_t          instruction,
    input  logic [xlen-1:0] pc_add4,
    input  logic            valid,
    input  wb_t             wb,
    output id_ex_t          decoded,
    output logic [4:0]      rs,
    output logic [4:0]      rt
);

    logic [xlen-1:0] regs [32];
    logic            wb_write;
    logic [xlen-1:0] rs_data;
    logic [xlen-1:0] rt_data;
    ctrl_t           ctrl;
    logic [4:0]      dest;

    assign rs = instruction.r_fields.rs;
    assign rt = instruction.r_fields.rt;

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        case (instruction.r_fields.op)
            op_rtype: begin
                ctrl.write_reg = 1'b1;
                case (instruction.r_fields.funct)
                    fn_add:  ctrl.alu_op = alu_add;
                    fn_sub:  ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    default: ctrl.write_reg = 1'b0;
                endcase
            end
            op_addi: begin
                ctrl.use_imm   = 1'b1;
                ctrl.write_reg = 1'b1;
            end
            op_lw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.write_reg = 1'b1;
            end
            op_sw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            op_beq: begin
                ctrl.alu_op = alu_sub;
                ctrl.branch = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // rd for register format, rt for everything else
    assign dest = (instruction.r_fields.op == op_rtype) ? instruction.r_fields.rd
                                                        : instruction.i_fields.rt;

    // r0 reads zero and is never written
    assign wb_write = wb.valid && wb.write_reg && (wb.dest != 5'd0);
    assign rs_data  = (rs == 5'd0) ? '0 : (wb_write && wb.dest == rs) ? wb.data : regs[rs];
    assign rt_data  = (rt == 5'd0) ? '0 : (wb_write && wb.dest == rt) ? wb.data : regs[rt];

    always_ff @(posedge clk) begin
        if (wb_write) begin
            regs[wb.dest] <= wb.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded.valid <= 1'b0;
        end else if (!freeze) begin
            decoded.valid   <= valid && !bubble && !flush;
            decoded.pc_add4 <= pc_add4;
            decoded.ctrl    <= ctrl;
            decoded.rs      <= rs;
            decoded.rt      <= rt;
            decoded.dest    <= dest;
            decoded.rs_data <= rs_data;
            decoded.rt_data <= rt_data;
            decoded.imm     <= {{16{instruction.i_fields.imm[15]}}, instruction.i_fields.imm};
        end
    end

    // the fetched word holds while the front end is stalled
    assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(instruction) && $stable(pc_add4) && $stable(valid));

endmodule

`default_nettype wire

//--- src/stage_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module stage_fetch import core_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            redirect,
    input  logic [xlen-1:0] target,
    input  logic            flush,
    output wb_req_t         bus_req,
    input  wb_rsp_t         bus_rsp,
    output instr_t          instruction,
    output logic [xlen-1:0] pc_add4,
    output logic            valid,
    output logic            busy
);

    logic [xlen-1:0] pc;
    logic            started;
    logic            skid_valid;
    instr_t          skid_word;

    // no new read while a returned word is parked
    assign bus_req.cyc   = started && !skid_valid;
    assign bus_req.stb   = started && !skid_valid;
    assign bus_req.we    = 1'b0;
    assign bus_req.adr   = pc;
    assign bus_req.dat_w = '0;
    assign busy          = bus_req.stb && !bus_rsp.ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= reset_pc;
            started    <= 1'b0;
            valid      <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (redirect) begin
                pc <= target;
            end else if (bus_rsp.ack) begin
                pc <= pc + xlen'(4);
            end
            if (flush) begin
                valid      <= 1'b0;
                skid_valid <= 1'b0;
            end else if (!stall) begin
                if (skid_valid) begin
                    // pc already points past the parked word
                    instruction <= skid_word;
                    pc_add4     <= pc;
                    valid       <= 1'b1;
                    skid_valid  <= 1'b0;
                end else begin
                    instruction <= bus_rsp.dat_r;
                    pc_add4     <= pc + xlen'(4);
                    valid       <= bus_rsp.ack;
                end
            end else if (bus_rsp.ack) begin
                skid_word  <= bus_rsp.dat_r;
                skid_valid <= 1'b1;
            end
        end
    end

    // a redirect never lands while a read is waiting, so the address holds
    assert property (@(posedge clk) disable iff (reset)
        bus_req.stb && !bus_rsp.ack |=> bus_req.stb && $stable(bus_req.adr));

endmodule

`default_nettype wire

//--- src/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = '0;

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;
    localparam logic [5:0] op_beq   = 6'h04;

    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2a;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // one fetched word, split as register or immediate format
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    write_reg;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc_add4;
        ctrl_t           ctrl;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [4:0]      dest;
        logic [xlen-1:0] rs_data;
        logic [xlen-1:0] rt_data;
        logic [xlen-1:0] imm;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        ctrl_t           ctrl;
        logic [4:0]      dest;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        logic            valid;
        logic            write_reg;
        logic [4:0]      dest;
        logic [xlen-1:0] data;
    } wb_t;

    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [xlen-1:0] adr;
        logic [xlen-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [xlen-1:0] dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire
